// ==== flist.f ====
cachePkg.sv
cacheTagTable.sv
lineTransferFsm.sv
flushWalker.sv
accessStage.sv
cacheController.sv
cacheControllerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cacheControllerTb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= Testbench failed

SIM_BIN = $(OBJ_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	echo "simulation ok"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cacheControllerTb.sv ====
`timescale 1ns/100ps

module cacheControllerTb;
    import cachePkg::*;

    localparam int NUM_SETS = 8;
    localparam int NUM_WAYS = 4;
    localparam int LINE_BYTES_LOG = 5;
    localparam int MAX_CREDITS = 2;
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int LINE_WORDS = 1 << (LINE_BYTES_LOG - 2);
    localparam int TIMEOUT = 400;
    localparam int FENCE_TIMEOUT = 4000;

    logic clk;
    logic rst;
    accessReqS req;
    logic reqReady;
    accessResS res;
    logic creditReturn;
    memReqS memReq;
    memResS memRes;
    logic fence;
    logic fenceBusy;

    // Reference copy of the tag table
    logic refValid [NUM_SETS][NUM_WAYS];
    logic refDirty [NUM_SETS][NUM_WAYS];
    tagT refTag [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] refUsed [NUM_SETS];

    accessResS expRes [$];
    memReqS expCmd [$];
    string testName;
    int errCount;
    int checkCount;
    int testCount;
    int resCount;
    int wbCount;
    int fillCount;
    int owedCredits;
    logic holdCredits;
    logic cmdPending;

    cacheController #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS),
        .LINE_BYTES_LOG(LINE_BYTES_LOG),
        .MAX_CREDITS(MAX_CREDITS)
    ) cacheController_i (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic sramAddrT sramOf(input int way, input int set, input int offset);
        return sramAddrT'((way << (SET_W + LINE_BYTES_LOG)) | (set << LINE_BYTES_LOG) | offset);
    endfunction

    function automatic lineAddrT lineOf(input tagT tag, input int set);
        return lineAddrT'(((32'(tag) << SET_W) | set) << (LINE_BYTES_LOG - 2));
    endfunction

    function automatic addrT makeAddr(input int tagSel, input int set, input int offset);
        addrT tagPart;
        tagPart = addrT'(24'h3a5000 + tagSel);
        return (tagPart << (SET_W + LINE_BYTES_LOG)) | addrT'(set << LINE_BYTES_LOG)
            | addrT'(offset);
    endfunction

    // Predicts one access and queues the memory commands it needs
    function automatic accessResS predictAccess(input addrT addr, input logic isStore);
        tagT tag;
        int set;
        int offset;
        int way;
        accessResS expected;
        tag = tagT'(addr >> (SET_W + LINE_BYTES_LOG));
        set = int'((addr >> LINE_BYTES_LOG) % NUM_SETS);
        offset = int'(addr % (1 << LINE_BYTES_LOG));
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++)
            if (refValid[set][w] && refTag[set][w] == tag)
                way = w;
        if (way < 0) begin
            for (int w = 0; w < NUM_WAYS; w++)
                if (!refValid[set][w])
                    way = w;
            if (way < 0) begin
                // Highest way whose used bit is clear
                way = 0;
                for (int w = 0; w < NUM_WAYS; w++)
                    if (!refUsed[set][w])
                        way = w;
                if (refDirty[set][way])
                    expCmd.push_back('{memCacheToExt, sramOf(way, set, 0),
                        lineOf(refTag[set][way], set)});
            end
            expCmd.push_back('{memExtToCache, sramOf(way, set, 0), lineOf(tag, set)});
            refValid[set][way] = 1'b1;
            refTag[set][way] = tag;
            refDirty[set][way] = 1'b0;
        end
        refUsed[set] = '0;
        refUsed[set][way] = 1'b1;
        if (isStore)
            refDirty[set][way] = 1'b1;
        expected.valid = 1'b1;
        expected.isStore = isStore;
        expected.sramAddr = sramOf(way, set, offset);
        return expected;
    endfunction

    // Walk order is set by set, way by way
    function automatic int predictFence();
        int count;
        count = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (refValid[s][w] && refDirty[s][w]) begin
                    expCmd.push_back('{memCacheToExt, sramOf(w, s, 0), lineOf(refTag[s][w], s)});
                    count++;
                end
                refValid[s][w] = 1'b0;
                refDirty[s][w] = 1'b0;
            end
            refUsed[s] = '0;
        end
        return count;
    endfunction

    task automatic logCommand();
        memReqS expected;
        if (memReq.cmd == memCacheToExt)
            wbCount++;
        else
            fillCount++;
        checkCount++;
        assert (expCmd.size() != 0) else begin
            $display("unexpected memory command %h in test %s", memReq, testName);
            errCount++;
        end
        if (expCmd.size() != 0) begin
            expected = expCmd.pop_front();
            assert (memReq == expected) else begin
                $display("mismatch %s: expected command %h, actual %h", testName, expected, memReq);
                errCount++;
            end
        end
    endtask

    // Memory controller model with busy one cycle after a command and then one word per cycle
    initial begin
        memRes = '0;
        cmdPending = 1'b0;
        forever begin
            @(negedge clk);
            if (memRes.busy) begin
                if (int'(memRes.progress) == LINE_WORDS)
                    memRes = '0;
                else
                    memRes.progress = memRes.progress + 1'b1;
            end else if (cmdPending) begin
                cmdPending = 1'b0;
                memRes.busy = 1'b1;
                memRes.progress = '0;
            end else if (memReq.cmd != memNone) begin
                cmdPending = 1'b1;
                logCommand();
            end
        end
    end

    // Result compare and downstream credit return
    initial begin
        accessResS expected;
        creditReturn = 1'b0;
        forever begin
            @(negedge clk);
            if (res.valid) begin
                resCount++;
                owedCredits++;
                checkCount++;
                assert (expRes.size() != 0) else begin
                    $display("unexpected result %h in test %s", res, testName);
                    errCount++;
                end
                if (expRes.size() != 0) begin
                    expected = expRes.pop_front();
                    assert (res == expected) else begin
                        $display("mismatch %s: expected %h, actual %h", testName, expected, res);
                        errCount++;
                    end
                end
            end
            if (!holdCredits && owedCredits > 0) begin
                creditReturn = 1'b1;
                owedCredits--;
            end else begin
                creditReturn = 1'b0;
            end
        end
    end

    task automatic driveAccess(input addrT addr, input logic isStore);
        expRes.push_back(predictAccess(addr, isStore));
        req.valid = 1'b1;
        req.isStore = isStore;
        req.addr = addr;
    endtask

    task automatic waitAccept();
        int waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            #1;
            accepted = reqReady;
            @(negedge clk);
            waited++;
        end
        req.valid = 1'b0;
        checkCount++;
        assert (accepted) else begin
            $display("access to %h in test %s was never accepted", req.addr, testName);
            errCount++;
        end
    endtask

    task automatic issueAccess(input addrT addr, input logic isStore);
        driveAccess(addr, isStore);
        waitAccept();
    endtask

    task automatic waitDrained();
        int waited;
        logic drained;
        waited = 0;
        drained = 1'b0;
        while (!drained && waited < TIMEOUT) begin
            @(posedge clk);
            drained = expRes.size() == 0 && expCmd.size() == 0 && owedCredits == 0
                && !memRes.busy && !cmdPending;
            waited++;
        end
        checkCount++;
        assert (drained) else begin
            $display("test %s timed out with %0d results and %0d memory commands missing",
                testName, expRes.size(), expCmd.size());
            errCount++;
            expRes.delete();
            expCmd.delete();
        end
        @(negedge clk);
    endtask

    task automatic checkDelta(input int fillStart, input int wbStart, input int expFill,
                              input int expWb);
        checkCount += 2;
        assert (fillCount - fillStart == expFill) else begin
            $display("mismatch %s: expected %0d fills, actual %0d", testName, expFill,
                fillCount - fillStart);
            errCount++;
        end
        assert (wbCount - wbStart == expWb) else begin
            $display("mismatch %s: expected %0d write-backs, actual %0d", testName, expWb,
                wbCount - wbStart);
            errCount++;
        end
    endtask

    task automatic runFence(output int expWb);
        int waited;
        logic stillBusy;
        expWb = predictFence();
        fence = 1'b1;
        #1;
        checkCount++;
        assert (fenceBusy) else begin
            $display("fenceBusy did not rise with the fence in test %s", testName);
            errCount++;
        end
        @(negedge clk);
        fence = 1'b0;
        waited = 0;
        stillBusy = 1'b1;
        while (stillBusy && waited < FENCE_TIMEOUT) begin
            #1;
            stillBusy = fenceBusy;
            @(negedge clk);
            waited++;
        end
        checkCount++;
        assert (!stillBusy) else begin
            $display("fenceBusy never fell in test %s", testName);
            errCount++;
        end
    endtask

    task automatic finishTest(input int errAtStart);
        testCount++;
        $display("test %s: %0d errors", testName, errCount - errAtStart);
    endtask

    initial begin
        int errAtStart;
        int fillAtStart;
        int wbAtStart;
        int resAtStart;
        int expWb;
        addrT addr;
        logic stillLow;
        void'($urandom(32'h72e2dbc0));
        rst = 1'b1;
        req = '0;
        fence = 1'b0;
        holdCredits = 1'b0;
        errCount = 0;
        checkCount = 0;
        testCount = 0;
        resCount = 0;
        wbCount = 0;
        fillCount = 0;
        owedCredits = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                refValid[s][w] = 1'b0;
                refDirty[s][w] = 1'b0;
                refTag[s][w] = '0;
            end
            refUsed[s] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        testName = "coldMiss";
        errAtStart = errCount;
        #1;
        checkCount++;
        assert (reqReady && !res.valid && memReq.cmd == memNone && !fenceBusy) else begin
            $display("outputs after reset are not idle in test %s", testName);
            errCount++;
        end
        @(negedge clk);
        fillAtStart = fillCount;
        wbAtStart = wbCount;
        issueAccess(makeAddr(0, 0, 12), 1'b0);
        waitDrained();
        checkDelta(fillAtStart, wbAtStart, 1, 0);
        finishTest(errAtStart);

        testName = "hitsAndReplacement";
        errAtStart = errCount;
        for (int t = 0; t < NUM_WAYS; t++)
            issueAccess(makeAddr(t, 3, t * 4), 1'b0);
        waitDrained();
        fillAtStart = fillCount;
        wbAtStart = wbCount;
        for (int t = NUM_WAYS - 1; t >= 0; t--)
            issueAccess(makeAddr(t, 3, 20 - t), 1'b0);
        issueAccess(makeAddr(0, 3, 0), 1'b0);
        waitDrained();
        checkDelta(fillAtStart, wbAtStart, 0, 0);
        fillAtStart = fillCount;
        issueAccess(makeAddr(NUM_WAYS, 3, 8), 1'b0);
        waitDrained();
        checkDelta(fillAtStart, wbAtStart, 1, 0);
        // Random loads over a few tags per set
        for (int i = 0; i < 40; i++)
            issueAccess(makeAddr(int'($urandom % 6), int'($urandom % 2),
                int'($urandom % 8) * 4), 1'b0);
        waitDrained();
        finishTest(errAtStart);

        testName = "dirtyWriteBack";
        errAtStart = errCount;
        for (int t = 0; t < NUM_WAYS; t++)
            issueAccess(makeAddr(t, 5, 0), 1'b0);
        issueAccess(makeAddr(0, 5, 8), 1'b1);
        // Move the used bit so the stored line becomes the victim
        issueAccess(makeAddr(1, 5, 0), 1'b0);
        waitDrained();
        fillAtStart = fillCount;
        wbAtStart = wbCount;
        issueAccess(makeAddr(NUM_WAYS, 5, 4), 1'b0);
        waitDrained();
        checkDelta(fillAtStart, wbAtStart, 1, 1);
        for (int i = 0; i < 40; i++)
            issueAccess(makeAddr(int'($urandom % 5), 4 + int'($urandom % 3),
                int'($urandom % 8) * 4), 1'(int'($urandom % 2)));
        waitDrained();
        finishTest(errAtStart);

        testName = "credits";
        errAtStart = errCount;
        addr = makeAddr(2, 1, 0);
        issueAccess(addr, 1'b0);
        waitDrained();
        @(posedge clk);
        holdCredits = 1'b1;
        @(negedge clk);
        resAtStart = resCount;
        for (int i = 0; i < MAX_CREDITS; i++)
            issueAccess(addr + addrT'(4 * i), 1'b0);
        driveAccess(addr + addrT'(16), 1'b1);
        stillLow = 1'b1;
        repeat (10) begin
            #1;
            if (reqReady)
                stillLow = 1'b0;
            @(negedge clk);
        end
        checkCount += 2;
        assert (stillLow) else begin
            $display("reqReady was high with no credits in test %s", testName);
            errCount++;
        end
        assert (resCount - resAtStart == MAX_CREDITS) else begin
            $display("mismatch %s: expected %0d results, actual %0d", testName, MAX_CREDITS,
                resCount - resAtStart);
            errCount++;
        end
        @(posedge clk);
        holdCredits = 1'b0;
        @(negedge clk);
        waitAccept();
        waitDrained();
        checkCount++;
        assert (resCount - resAtStart == MAX_CREDITS + 1) else begin
            $display("mismatch %s: expected %0d results, actual %0d", testName,
                MAX_CREDITS + 1, resCount - resAtStart);
            errCount++;
        end
        finishTest(errAtStart);

        testName = "fence";
        errAtStart = errCount;
        issueAccess(makeAddr(3, 2, 0), 1'b1);
        issueAccess(makeAddr(1, 6, 4), 1'b1);
        waitDrained();
        fillAtStart = fillCount;
        wbAtStart = wbCount;
        runFence(expWb);
        waitDrained();
        checkDelta(fillAtStart, wbAtStart, 0, expWb);
        fillAtStart = fillCount;
        wbAtStart = wbCount;
        issueAccess(makeAddr(3, 2, 0), 1'b0);
        waitDrained();
        checkDelta(fillAtStart, wbAtStart, 1, 0);
        finishTest(errAtStart);

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== cacheController.sv ====
`timescale 1ns/100ps

module cacheController #(
    parameter int NUM_SETS = cachePkg::DEF_NUM_SETS,
    parameter int NUM_WAYS = cachePkg::DEF_NUM_WAYS,
    parameter int LINE_BYTES_LOG = cachePkg::DEF_LINE_BYTES_LOG,
    parameter int MAX_CREDITS = 2
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::accessReqS req,
    output logic reqReady,
    output cachePkg::accessResS res,
    input  logic creditReturn,
    output cachePkg::memReqS memReq,
    input  cachePkg::memResS memRes,
    input  logic fence,
    output logic fenceBusy
);
    import cachePkg::*;

    setIdxT lookupSet;
    tagT lookupTag;
    logic hit;
    wayIdxT hitWay;
    logic freeAvail;
    wayIdxT freeWay;
    wayIdxT victimWay;
    logic victimDirty;
    tagT victimTag;
    setIdxT walkSet;
    wayIdxT walkWay;
    logic walkValid;
    logic walkDirty;
    tagT walkTag;
    tagUpdateS update;
    tagUpdateS flushUpdate;
    tagUpdateS fillDone;
    logic xferIdle;
    logic flushBusy;
    logic pipeEmpty;

    // Start requests from the access stage and the walker
    logic accStart;
    logic accNeedEvict;
    logic needFill;
    setIdxT startSet;
    wayIdxT startWay;
    lineAddrT accEvictLine;
    lineAddrT fillLine;
    logic evictStart;
    lineAddrT evictLine;

    logic xStart;
    logic xNeedEvict;
    logic xNeedFill;
    setIdxT xSet;
    wayIdxT xWay;
    lineAddrT xEvictLine;

    // Access starts are blocked during a flush, and the walker only writes back
    assign xStart = flushBusy ? evictStart : accStart;
    assign xNeedEvict = flushBusy || accNeedEvict;
    assign xNeedFill = !flushBusy && needFill;
    assign xSet = flushBusy ? walkSet : startSet;
    assign xWay = flushBusy ? walkWay : startWay;
    assign xEvictLine = flushBusy ? evictLine : accEvictLine;

    assign fenceBusy = flushBusy;

    cacheTagTable #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) cacheTagTable_i (
        .*,
        .fill(fillDone)
    );

    lineTransferFsm #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS),
        .LINE_BYTES_LOG(LINE_BYTES_LOG)
    ) lineTransferFsm_i (
        .*,
        .startValid(xStart),
        .needEvict(xNeedEvict),
        .needFill(xNeedFill),
        .set(xSet),
        .way(xWay),
        .evictLine(xEvictLine)
    );

    flushWalker #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) flushWalker_i (
        .*
    );

    accessStage #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS),
        .LINE_BYTES_LOG(LINE_BYTES_LOG),
        .MAX_CREDITS(MAX_CREDITS)
    ) accessStage_i (
        .*,
        .startValid(accStart),
        .needEvict(accNeedEvict),
        .evictLine(accEvictLine)
    );

endmodule

// ==== accessStage.sv ====
`timescale 1ns/100ps

module accessStage #(
    parameter int NUM_SETS = cachePkg::DEF_NUM_SETS,
    parameter int NUM_WAYS = cachePkg::DEF_NUM_WAYS,
    parameter int LINE_BYTES_LOG = cachePkg::DEF_LINE_BYTES_LOG,
    parameter int MAX_CREDITS = 2
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::accessReqS req,
    output logic reqReady,
    output cachePkg::accessResS res,
    input  logic creditReturn,
    output cachePkg::setIdxT lookupSet,
    output cachePkg::tagT lookupTag,
    input  logic hit,
    input  cachePkg::wayIdxT hitWay,
    input  logic freeAvail,
    input  cachePkg::wayIdxT freeWay,
    input  cachePkg::wayIdxT victimWay,
    input  logic victimDirty,
    input  cachePkg::tagT victimTag,
    output cachePkg::tagUpdateS update,
    input  logic xferIdle,
    input  logic flushBusy,
    output logic startValid,
    output logic needEvict,
    output logic needFill,
    output cachePkg::setIdxT startSet,
    output cachePkg::wayIdxT startWay,
    output cachePkg::lineAddrT evictLine,
    output cachePkg::lineAddrT fillLine,
    output logic pipeEmpty
);
    import cachePkg::*;

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TAG_W = 32 - SET_W - LINE_BYTES_LOG;
    localparam int CREDIT_W = $clog2(MAX_CREDITS + 1);

    logic [CREDIT_W-1:0] credits;
    logic [LINE_BYTES_LOG-1:0] offset;
    logic missing;
    logic accept;
    logic resValid;
    logic resStore;
    sramAddrT resAddr;

    assign lookupTag = req.addr[31 -: TAG_W];
    assign lookupSet = req.addr[LINE_BYTES_LOG +: SET_W];
    assign offset = req.addr[LINE_BYTES_LOG-1:0];

    assign missing = req.valid && !hit;
    assign reqReady = !flushBusy && credits != '0 && !missing;
    assign accept = req.valid && reqReady;
    assign pipeEmpty = !resValid;

    // Prefer a free way, else replace the victim after writing it back if dirty
    assign startValid = missing && xferIdle && !flushBusy;
    assign needFill = 1'b1;
    assign needEvict = !freeAvail && victimDirty;
    assign startSet = lookupSet;
    assign startWay = freeAvail ? freeWay : victimWay;
    assign evictLine = {victimTag, lookupSet, {(LINE_BYTES_LOG-2){1'b0}}};
    assign fillLine = {lookupTag, lookupSet, {(LINE_BYTES_LOG-2){1'b0}}};

    always_comb begin
        update.valid = accept;
        update.set = lookupSet;
        update.way = hitWay;
        update.op = req.isStore ? tagDirty : tagTouch;
        update.tag = lookupTag;
    end

    always_comb begin
        res.valid = resValid;
        res.isStore = resStore;
        res.sramAddr = resAddr;
    end

    // Credit leaves the count in the same cycle the result shows up
    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            credits <= CREDIT_W'(MAX_CREDITS);
        end else begin
            resValid <= accept;
            credits <= credits - CREDIT_W'(accept) + CREDIT_W'(creditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resStore <= req.isStore;
            resAddr <= {hitWay[WAY_W-1:0], lookupSet, offset};
        end
    end

    // Downstream never returns more credits than it was handed
    assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_W'(MAX_CREDITS));

endmodule

// ==== flushWalker.sv ====
`timescale 1ns/100ps

module flushWalker #(
    parameter int NUM_SETS = cachePkg::DEF_NUM_SETS,
    parameter int NUM_WAYS = cachePkg::DEF_NUM_WAYS
) (
    input  logic clk,
    input  logic rst,
    input  logic fence,
    input  logic pipeEmpty,
    input  logic xferIdle,
    input  logic walkValid,
    input  logic walkDirty,
    input  cachePkg::tagT walkTag,
    output cachePkg::setIdxT walkSet,
    output cachePkg::wayIdxT walkWay,
    output cachePkg::tagUpdateS flushUpdate,
    output logic evictStart,
    output cachePkg::lineAddrT evictLine,
    output logic flushBusy
);
    import cachePkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int ITER_W = $clog2(NUM_SETS) + WAY_W;

    logic waiting;
    logic active;
    // Top bit set once every way has been visited
    logic [ITER_W:0] iter;
    logic walkDone;
    logic canStep;

    assign walkDone = iter[ITER_W];
    assign walkWay = iter[WAY_W-1:0];
    assign walkSet = iter[ITER_W-1:WAY_W];

    // Dirty ways hold until the transfer FSM is free
    assign canStep = !walkValid || !walkDirty || xferIdle;
    assign evictStart = active && !walkDone && walkValid && walkDirty && xferIdle;
    assign evictLine = {walkTag, walkSet, {WORD_OFF_BITS{1'b0}}};
    assign flushBusy = fence || waiting || active;

    always_comb begin
        flushUpdate.valid = active && !walkDone && walkValid && canStep;
        flushUpdate.set = walkSet;
        flushUpdate.way = walkWay;
        flushUpdate.op = tagInval;
        flushUpdate.tag = walkTag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
            active <= 1'b0;
            iter <= '0;
        end else begin
            if (fence) begin
                waiting <= 1'b1;
            end else if (waiting && !active && pipeEmpty && xferIdle) begin
                waiting <= 1'b0;
                active <= 1'b1;
                iter <= '0;
            end
            if (active) begin
                if (!walkDone && canStep)
                    iter <= iter + 1'b1;
                else if (walkDone && xferIdle)
                    active <= 1'b0;
            end
        end
    end

endmodule

// ==== lineTransferFsm.sv ====
`timescale 1ns/100ps

module lineTransferFsm #(
    parameter int NUM_SETS = cachePkg::DEF_NUM_SETS,
    parameter int NUM_WAYS = cachePkg::DEF_NUM_WAYS,
    parameter int LINE_BYTES_LOG = cachePkg::DEF_LINE_BYTES_LOG
) (
    input  logic clk,
    input  logic rst,
    input  logic startValid,
    input  logic needEvict,
    input  logic needFill,
    input  cachePkg::setIdxT set,
    input  cachePkg::wayIdxT way,
    input  cachePkg::lineAddrT evictLine,
    input  cachePkg::lineAddrT fillLine,
    output logic xferIdle,
    output cachePkg::tagUpdateS fillDone,
    output cachePkg::memReqS memReq,
    input  cachePkg::memResS memRes
);
    import cachePkg::*;

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TAG_W = 32 - SET_W - LINE_BYTES_LOG;
    localparam int LINE_WORDS = 1 << (LINE_BYTES_LOG - 2);

    xferStateE state;
    memCmdE cmdQ;
    sramAddrT sramQ;
    lineAddrT extQ;
    lineAddrT pendingFill;
    logic lineDone;

    assign lineDone = !memRes.busy || int'(memRes.progress) == LINE_WORDS;
    assign xferIdle = state == xIdle;

    always_comb begin
        memReq.cmd = cmdQ;
        memReq.sramAddr = sramQ;
        memReq.extAddr = extQ;
    end

    // Set, way and tag come back out of the running command
    always_comb begin
        fillDone.valid = state == xLoadActive && lineDone;
        fillDone.set = sramQ[LINE_BYTES_LOG +: SET_W];
        fillDone.way = sramQ[LINE_BYTES_LOG + SET_W +: WAY_W];
        fillDone.op = tagFill;
        fillDone.tag = extQ[29 -: TAG_W];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= xIdle;
            cmdQ <= memNone;
        end else begin
            case (state)
                xIdle: begin
                    if (startValid && needEvict) begin
                        cmdQ <= memCacheToExt;
                        state <= needFill ? xReplaceRq : xEvictRq;
                    end else if (startValid && needFill) begin
                        cmdQ <= memExtToCache;
                        state <= xLoadRq;
                    end
                end
                xEvictRq, xLoadRq, xReplaceRq: begin
                    if (memRes.busy) begin
                        cmdQ <= memNone;
                        state <= xferStateE'(state + 3'd1);
                    end
                end
                xEvictActive, xLoadActive: begin
                    if (lineDone)
                        state <= xIdle;
                end
                xReplaceActive: begin
                    if (lineDone) begin
                        cmdQ <= memExtToCache;
                        state <= xLoadRq;
                    end
                end
                default: state <= xIdle;
            endcase
        end
    end

    // Write-back and fill share the SRAM line
    always_ff @(posedge clk) begin
        if (xferIdle && startValid) begin
            sramQ <= {way, set, {LINE_BYTES_LOG{1'b0}}};
            extQ <= needEvict ? evictLine : fillLine;
            pendingFill <= fillLine;
        end else if (state == xReplaceActive && lineDone) begin
            extQ <= pendingFill;
        end
    end

    // Both requesters check xferIdle before starting
    assert property (@(posedge clk) disable iff (rst) startValid |-> xferIdle);

    assert property (@(posedge clk) disable iff (rst)
        (cmdQ != memNone && memRes.busy) |=> cmdQ == memNone);

endmodule

// ==== cacheTagTable.sv ====
`timescale 1ns/100ps

module cacheTagTable #(
    parameter int NUM_SETS = cachePkg::DEF_NUM_SETS,
    parameter int NUM_WAYS = cachePkg::DEF_NUM_WAYS
) (
    input  logic clk,
    input  logic rst,
    input  cachePkg::setIdxT lookupSet,
    input  cachePkg::tagT lookupTag,
    output logic hit,
    output cachePkg::wayIdxT hitWay,
    output logic freeAvail,
    output cachePkg::wayIdxT freeWay,
    output cachePkg::wayIdxT victimWay,
    output logic victimDirty,
    output cachePkg::tagT victimTag,
    input  cachePkg::setIdxT walkSet,
    input  cachePkg::wayIdxT walkWay,
    output logic walkValid,
    output logic walkDirty,
    output cachePkg::tagT walkTag,
    input  cachePkg::tagUpdateS update,
    input  cachePkg::tagUpdateS flushUpdate,
    input  cachePkg::tagUpdateS fill
);
    import cachePkg::*;

    tagT tagMem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] validBits [NUM_SETS];
    logic [NUM_WAYS-1:0] dirtyBits [NUM_SETS];
    logic [NUM_WAYS-1:0] usedBits [NUM_SETS];
    logic [NUM_WAYS-1:0] hitVec;
    tagUpdateS updates [3];

    // Applied in index order, so the access stage wins a collision
    assign updates[0] = fill;
    assign updates[1] = flushUpdate;
    assign updates[2] = update;

    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        freeAvail = 1'b0;
        freeWay = '0;
        victimWay = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hitVec[w] = validBits[lookupSet][w] && tagMem[lookupSet][w] == lookupTag;
            if (hitVec[w]) begin
                hit = 1'b1;
                hitWay = wayIdxT'(w);
            end
            if (!validBits[lookupSet][w]) begin
                freeAvail = 1'b1;
                freeWay = wayIdxT'(w);
            end
            // Highest way not touched last
            if (!usedBits[lookupSet][w])
                victimWay = wayIdxT'(w);
        end
    end

    assign victimDirty = dirtyBits[lookupSet][victimWay];
    assign victimTag = tagMem[lookupSet][victimWay];

    assign walkValid = validBits[walkSet][walkWay];
    assign walkDirty = dirtyBits[walkSet][walkWay];
    assign walkTag = tagMem[walkSet][walkWay];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                validBits[s] <= '0;
                dirtyBits[s] <= '0;
                usedBits[s] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (updates[i].valid) begin
                    case (updates[i].op)
                        tagTouch: usedBits[updates[i].set] <= NUM_WAYS'(1) << updates[i].way;
                        tagDirty: begin
                            usedBits[updates[i].set] <= NUM_WAYS'(1) << updates[i].way;
                            dirtyBits[updates[i].set][updates[i].way] <= 1'b1;
                        end
                        tagFill: begin
                            validBits[updates[i].set][updates[i].way] <= 1'b1;
                            dirtyBits[updates[i].set][updates[i].way] <= 1'b0;
                        end
                        default: begin
                            validBits[updates[i].set][updates[i].way] <= 1'b0;
                            dirtyBits[updates[i].set][updates[i].way] <= 1'b0;
                            usedBits[updates[i].set][updates[i].way] <= 1'b0;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (updates[i].valid && updates[i].op == tagFill)
                tagMem[updates[i].set][updates[i].way] <= updates[i].tag;
        end
    end

    // Fills only ever bring in missing lines, so a tag lives in one way at most
    assert property (@(posedge clk) disable iff (rst) $onehot0(hitVec));

endmodule

// ==== cachePkg.sv ====
package cachePkg;

    // Geometry defaults that the top level may override
    localparam int DEF_NUM_SETS = 8;
    localparam int DEF_NUM_WAYS = 4;
    localparam int DEF_LINE_BYTES_LOG = 5;

    localparam int SET_BITS = $clog2(DEF_NUM_SETS);
    localparam int WAY_BITS = $clog2(DEF_NUM_WAYS);
    localparam int TAG_BITS = 32 - SET_BITS - DEF_LINE_BYTES_LOG;
    localparam int WORD_OFF_BITS = DEF_LINE_BYTES_LOG - 2;

    typedef logic [31:0] addrT;
    typedef logic [TAG_BITS-1:0] tagT;
    typedef logic [SET_BITS-1:0] setIdxT;
    typedef logic [WAY_BITS-1:0] wayIdxT;
    typedef logic [WAY_BITS+SET_BITS+DEF_LINE_BYTES_LOG-1:0] sramAddrT;
    // Word address of a line start
    typedef logic [29:0] lineAddrT;

    typedef enum logic [1:0] {memNone, memCacheToExt, memExtToCache} memCmdE;

    typedef enum logic [1:0] {tagTouch, tagDirty, tagFill, tagInval} tagOpE;

    // Each request state is directly followed by its active state
    typedef enum logic [2:0] {
        xIdle, xEvictRq, xEvictActive, xLoadRq, xLoadActive, xReplaceRq, xReplaceActive
    } xferStateE;

    typedef struct packed {
        logic valid;
        logic isStore;
        addrT addr;
    } accessReqS;

    typedef struct packed {
        logic valid;
        logic isStore;
        sramAddrT sramAddr;
    } accessResS;

    typedef struct packed {
        memCmdE cmd;
        sramAddrT sramAddr;
        lineAddrT extAddr;
    } memReqS;

    typedef struct packed {
        logic busy;
        logic [WORD_OFF_BITS:0] progress;
    } memResS;

    typedef struct packed {
        logic valid;
        setIdxT set;
        wayIdxT way;
        tagOpE op;
        tagT tag;
    } tagUpdateS;

endpackage
